/* Makefile */
# Verilator simulation of the division unit

VERILATOR ?= verilator
TOP       ?= div_unit_tb
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= === PASS ===

.PHONY: sim clean

# pass or fail comes from the log, not from the simulator's exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/div_pkg.sv */
`default_nettype none

package div_pkg;

    // operand width, fixed because the structs below carry it
    localparam int DIV_WIDTH = 32;

    typedef logic [DIV_WIDTH-1:0] div_word_t;

    // request as presented at the unit boundary
    typedef struct packed {
        div_word_t dividend;
        div_word_t divisor;
        logic      is_signed;
    } div_req_t;

    // magnitudes plus the signs to restore afterwards
    typedef struct packed {
        div_word_t dividend;
        div_word_t divisor;
        logic      dividend_sign;
        logic      quotient_sign;
    } div_op_t;

    // raw divider output, still in magnitude form
    typedef struct packed {
        div_word_t quotient;
        div_word_t remainder;
        logic      quotient_sign;
        logic      remainder_sign;
        logic      divide_by_zero;
    } div_raw_t;

    // two's complement result seen outside
    typedef struct packed {
        div_word_t quotient;
        div_word_t remainder;
        logic      divide_by_zero;
    } div_resp_t;

    typedef enum logic [1:0] {
        state_idle,
        state_run,
        state_finish
    } div_state_t;

endpackage

`default_nettype wire

/* hdl/div_request_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module div_request_stage
    import div_pkg::*;
(
    input  wire logic     clk_in,
    input  wire logic     reset_in,
    input  wire logic     req_valid,
    input  wire div_req_t req,
    input  wire logic     idle,
    input  wire logic     has_credit,
    output logic          busy,
    output logic          issue,
    output div_op_t       op
);

    div_req_t pending;
    logic     accept;
    logic     dividend_neg;
    logic     divisor_neg;

    // a pulse while busy is dropped
    assign accept = req_valid && !busy;

    // divider must be free and a result slot must be available
    assign issue = busy && idle && has_credit;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            busy <= 1'b0;
        end
        else if (issue)
        begin
            busy <= 1'b0;
        end
        else if (accept)
        begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept)
        begin
            pending <= req;
        end
    end

    // sign and magnitude split
    always_comb
    begin
        dividend_neg = pending.is_signed && pending.dividend[DIV_WIDTH-1];
        divisor_neg  = pending.is_signed && pending.divisor[DIV_WIDTH-1];

        // most negative value maps onto itself, which is the right magnitude
        if (dividend_neg)
        begin
            op.dividend = div_word_t'(-pending.dividend);
        end
        else
        begin
            op.dividend = pending.dividend;
        end

        if (divisor_neg)
        begin
            op.divisor = div_word_t'(-pending.divisor);
        end
        else
        begin
            op.divisor = pending.divisor;
        end

        op.dividend_sign = dividend_neg;
        op.quotient_sign = dividend_neg ^ divisor_neg;
    end

endmodule

`default_nettype wire

/* hdl/div_result_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module div_result_buffer
    import div_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  wire logic     clk_in,
    input  wire logic     reset_in,
    input  wire logic     reserve,
    input  wire logic     write,
    input  wire div_raw_t write_data,
    input  wire logic     pop,
    output logic          has_credit,
    output logic          not_empty,
    output div_raw_t      head
);

    localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [PTR_W-1:0]   ptr_t;
    typedef logic [COUNT_W-1:0] count_t;

    localparam ptr_t   LAST_SLOT   = ptr_t'(FIFO_DEPTH - 1);
    localparam count_t DEPTH_COUNT = count_t'(FIFO_DEPTH);

    div_raw_t mem [FIFO_DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;

    // stored plus reserved, so an issued division always has a slot
    count_t   occupancy;
    count_t   stored;

    assign has_credit = (occupancy != DEPTH_COUNT);
    assign not_empty  = (stored != '0);
    assign head       = mem[rd_ptr];

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            stored    <= '0;
        end
        else
        begin
            if (write)
            begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end

            case ({reserve, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase

            case ({write, pop})
                2'b10:   stored <= stored + 1'b1;
                2'b01:   stored <= stored - 1'b1;
                default: stored <= stored;
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (write)
        begin
            mem[wr_ptr] <= write_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/div_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module div_unit_top
    import div_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  wire logic     clk_in,
    input  wire logic     reset_in,
    input  wire logic     req_valid,
    input  wire div_req_t req,
    output logic          busy,
    output logic          result_valid,
    output div_resp_t     result,
    input  wire logic     result_read
);

    logic     issue;
    div_op_t  op;
    logic     idle;
    logic     done;
    div_raw_t raw;
    logic     has_credit;
    logic     not_empty;
    div_raw_t head;
    logic     pop;

    div_request_stage u_request (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .req_valid  (req_valid),
        .req        (req),
        .idle       (idle),
        .has_credit (has_credit),
        .busy       (busy),
        .issue      (issue),
        .op         (op)
    );

    integer_divider u_divider (
        .clk_in   (clk_in),
        .reset_in (reset_in),
        .issue    (issue),
        .op       (op),
        .idle     (idle),
        .done     (done),
        .raw      (raw)
    );

    // issue reserves the slot that done later fills
    div_result_buffer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_buffer (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .reserve    (issue),
        .write      (done),
        .write_data (raw),
        .pop        (pop),
        .has_credit (has_credit),
        .not_empty  (not_empty),
        .head       (head)
    );

    div_writeback_stage u_writeback (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .not_empty    (not_empty),
        .head         (head),
        .pop          (pop),
        .result_read  (result_read),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

/* hdl/div_writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module div_writeback_stage
    import div_pkg::*;
(
    input  wire logic     clk_in,
    input  wire logic     reset_in,
    input  wire logic     not_empty,
    input  wire div_raw_t head,
    output logic          pop,
    input  wire logic     result_read,
    output logic          result_valid,
    output div_resp_t     result
);

    div_word_t quotient_signed;
    div_word_t remainder_signed;

    // next head only once the held result is gone
    assign pop = not_empty && !result_valid;

    // back to two's complement
    always_comb
    begin
        quotient_signed  = head.quotient_sign ? div_word_t'(-head.quotient) : head.quotient;
        remainder_signed = head.remainder_sign ? div_word_t'(-head.remainder) : head.remainder;
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            result_valid <= 1'b0;
        end
        else if (pop)
        begin
            result_valid <= 1'b1;
        end
        else if (result_read)
        begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (pop)
        begin
            // divide by zero: all ones, remainder already equals the dividend
            result.quotient       <= head.divide_by_zero ? '1 : quotient_signed;
            result.remainder      <= remainder_signed;
            result.divide_by_zero <= head.divide_by_zero;
        end
    end

endmodule

`default_nettype wire

/* hdl/integer_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module integer_divider
    import div_pkg::*;
(
    input  wire logic    clk_in,
    input  wire logic    reset_in,
    input  wire logic    issue,
    input  wire div_op_t op,
    output logic         idle,
    output logic         done,
    output div_raw_t     raw
);

    localparam int COUNT_W = $clog2(DIV_WIDTH);
    localparam int WORK_W  = 2 * DIV_WIDTH + 1;

    typedef logic [COUNT_W-1:0] step_count_t;

    localparam step_count_t LAST_STEP = step_count_t'(DIV_WIDTH - 1);

    div_state_t        state;
    step_count_t       step_count;

    // {carry, partial remainder, dividend/quotient}
    logic [WORK_W-1:0] work;
    div_word_t         divisor_q;
    logic              dividend_sign_q;
    logic              quotient_sign_q;
    logic              zero_q;

    logic [WORK_W-1:0]    shifted;
    logic [DIV_WIDTH+1:0] trial;
    logic                 borrow;
    logic [DIV_WIDTH:0]   next_upper;

    assign idle = (state == state_idle);
    assign done = (state == state_finish);

    // one restoring step
    always_comb
    begin
        shifted    = {work[WORK_W-2:0], 1'b0};
        trial      = {1'b0, shifted[WORK_W-1:DIV_WIDTH]} - {2'b00, divisor_q};
        borrow     = trial[DIV_WIDTH+1];
        next_upper = borrow ? shifted[WORK_W-1:DIV_WIDTH] : trial[DIV_WIDTH:0];
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            state      <= state_idle;
            step_count <= '0;
        end
        else
        begin
            case (state)
                state_idle:
                begin
                    if (issue)
                    begin
                        state      <= state_run;
                        step_count <= '0;
                    end
                end
                state_run:
                begin
                    // zero divisor leaves at once without stepping
                    if (zero_q || step_count == LAST_STEP)
                    begin
                        state <= state_finish;
                    end
                    else
                    begin
                        step_count <= step_count + 1'b1;
                    end
                end
                state_finish:
                begin
                    state <= state_idle;
                end
                default:
                begin
                    state <= state_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (idle && issue)
        begin
            work            <= {{(DIV_WIDTH + 1){1'b0}}, op.dividend};
            divisor_q       <= op.divisor;
            dividend_sign_q <= op.dividend_sign;
            quotient_sign_q <= op.quotient_sign;
            zero_q          <= (op.divisor == '0);
        end
        else if (state == state_run && !zero_q)
        begin
            // quotient bit enters at the bottom
            work <= {next_upper, shifted[DIV_WIDTH-1:1], !borrow};
        end
    end

    // zero divisor leaves the dividend untouched in the low half
    always_comb
    begin
        if (zero_q)
        begin
            raw.quotient  = '1;
            raw.remainder = work[DIV_WIDTH-1:0];
        end
        else
        begin
            raw.quotient  = work[DIV_WIDTH-1:0];
            raw.remainder = work[2*DIV_WIDTH-1:DIV_WIDTH];
        end
        raw.quotient_sign  = quotient_sign_q;
        raw.remainder_sign = dividend_sign_q;
        raw.divide_by_zero = zero_q;
    end

endmodule

`default_nettype wire

/* tests/div_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb
    import div_pkg::*;
;

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DELAY    = 10;
    localparam int RESET_CYCLES   = 5;
    localparam int FIFO_DEPTH     = 4;
    localparam int RANDOM_COUNT   = 200;
    localparam int BURST_COUNT    = 6;
    localparam int TOTAL_REQUESTS = 6 + 6 + 4 + BURST_COUNT + RANDOM_COUNT;
    localparam int HOLD_CYCLES    = 2 * (DIV_WIDTH + 2);
    localparam int WATCHDOG_CYCLES = TOTAL_REQUESTS * (DIV_WIDTH + 10) + 200;
    localparam logic [31:0] LFSR_SEED = 32'hd7de_4feb;

    localparam div_word_t MOST_NEG  = {1'b1, {(DIV_WIDTH - 1){1'b0}}};
    localparam div_word_t MINUS_ONE = '1;

    logic      clk_in;
    logic      reset_in;
    logic      req_valid;
    div_req_t  req;
    logic      busy;
    logic      result_valid;
    div_resp_t result;
    logic      result_read;

    logic [31:0] lfsr_state;
    div_resp_t   expected_q[$];
    div_req_t    random_reqs[RANDOM_COUNT];
    int          read_gaps[RANDOM_COUNT];

    div_unit_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .req_valid    (req_valid),
        .req          (req),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result),
        .result_read  (result_read)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    // taps of x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic div_req_t make_req(input div_word_t dividend, input div_word_t divisor,
                                          input logic is_signed);
        div_req_t r;
        r.dividend  = dividend;
        r.divisor   = divisor;
        r.is_signed = is_signed;
        return r;
    endfunction

    // expected result straight from the arithmetic rules
    function automatic div_resp_t reference_result(input div_req_t r);
        div_resp_t e;
        e.divide_by_zero = 1'b0;
        if (r.divisor == '0)
        begin
            e.quotient       = '1;
            e.remainder      = r.dividend;
            e.divide_by_zero = 1'b1;
        end
        else if (r.is_signed && r.dividend == MOST_NEG && r.divisor == MINUS_ONE)
        begin
            e.quotient  = MOST_NEG;
            e.remainder = '0;
        end
        else if (r.is_signed)
        begin
            e.quotient  = $signed(r.dividend) / $signed(r.divisor);
            e.remainder = $signed(r.dividend) % $signed(r.divisor);
        end
        else
        begin
            e.quotient  = r.dividend / r.divisor;
            e.remainder = r.dividend % r.divisor;
        end
        return e;
    endfunction

    task automatic stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input div_word_t expected,
                               input div_word_t actual);
        assert (actual == expected)
        else
        begin
            $display("Error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    // all driving happens a short delay after the rising edge
    task automatic next_cycle();
        @(posedge clk_in);
        #DRIVE_DELAY;
    endtask

    task automatic send_request(input div_req_t r);
        while (busy)
        begin
            next_cycle();
        end
        req       = r;
        req_valid = 1'b1;
        expected_q.push_back(reference_result(r));
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic read_result();
        div_resp_t expected;
        while (!result_valid)
        begin
            next_cycle();
        end
        assert (expected_q.size() > 0)
        else
        begin
            $display("Result appeared at %0t ns with no request outstanding", $time);
            stop_with_failure();
        end
        expected = expected_q.pop_front();
        check_value("result.quotient", expected.quotient, result.quotient);
        check_value("result.remainder", expected.remainder, result.remainder);
        check_value("result.divide_by_zero", div_word_t'(expected.divide_by_zero),
                    div_word_t'(result.divide_by_zero));
        result_read = 1'b1;
        next_cycle();
        result_read = 1'b0;
    endtask

    task automatic divide_once(input div_word_t dividend, input div_word_t divisor,
                               input logic is_signed);
        send_request(make_req(dividend, divisor, is_signed));
        read_result();
    endtask

    task automatic test_unsigned_pairs();
        divide_once(32'd100, 32'd7, 1'b0);
        divide_once(32'd7, 32'd100, 1'b0);
        divide_once(32'hffff_ffff, 32'd1, 1'b0);
        divide_once(32'hdead_beef, 32'h0000_1234, 1'b0);
        divide_once(32'd12345678, 32'd12345678, 1'b0);
        divide_once(MOST_NEG, 32'd3, 1'b0);
    endtask

    task automatic test_signed_pairs();
        divide_once(32'd7, 32'd2, 1'b1);
        divide_once(-32'sd7, 32'd2, 1'b1);
        divide_once(32'd7, -32'sd2, 1'b1);
        divide_once(-32'sd7, -32'sd2, 1'b1);
        divide_once(MOST_NEG, MINUS_ONE, 1'b1);
        divide_once(MOST_NEG, 32'd1, 1'b1);
    endtask

    task automatic test_divide_by_zero();
        divide_once(32'd1234, 32'd0, 1'b0);
        divide_once(32'hffff_ffff, 32'd0, 1'b0);
        divide_once(-32'sd5, 32'd0, 1'b1);
        divide_once(MOST_NEG, 32'd0, 1'b1);
    endtask

    task automatic test_back_pressure();
        for (int i = 0; i < BURST_COUNT; i++)
        begin
            send_request(make_req(32'd1000 + div_word_t'(i), div_word_t'(i + 1), i[0]));
        end
        // held result plus a full buffer keep the last request waiting
        repeat (HOLD_CYCLES)
        begin
            check_value("busy", div_word_t'(1'b1), div_word_t'(busy));
            next_cycle();
        end
        for (int i = 0; i < BURST_COUNT; i++)
        begin
            read_result();
        end
    endtask

    task automatic test_random_stream();
        logic [31:0] bits;
        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
            bits = take_bits(2);
            random_reqs[i].dividend = take_bits(32);
            // small divisors now and then including zero
            if (bits[1:0] == 2'b00)
            begin
                random_reqs[i].divisor = take_bits(4);
            end
            else
            begin
                random_reqs[i].divisor = take_bits(32);
            end
            bits = take_bits(1);
            random_reqs[i].is_signed = bits[0];
            read_gaps[i] = int'(take_bits(3));
        end
        fork
            begin
                for (int i = 0; i < RANDOM_COUNT; i++)
                begin
                    send_request(random_reqs[i]);
                end
            end
            begin
                for (int i = 0; i < RANDOM_COUNT; i++)
                begin
                    repeat (read_gaps[i]) next_cycle();
                    read_result();
                end
            end
        join
    endtask

    task automatic test_drained();
        repeat (3) next_cycle();
        check_value("result_valid", '0, div_word_t'(result_valid));
        check_value("busy", '0, div_word_t'(busy));
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $fatal(1);
    end

    initial
    begin
        clk_in      = 1'b0;
        reset_in    = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        result_read = 1'b0;
        lfsr_state  = LFSR_SEED;

        repeat (RESET_CYCLES) @(posedge clk_in);
        #DRIVE_DELAY;
        reset_in = 1'b0;
        check_value("busy", '0, div_word_t'(busy));
        check_value("result_valid", '0, div_word_t'(result_valid));

        test_unsigned_pairs();
        test_signed_pairs();
        test_divide_by_zero();
        test_back_pressure();
        test_random_stream();
        test_drained();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/div_pkg.sv
hdl/div_request_stage.sv
hdl/integer_divider.sv
hdl/div_result_buffer.sv
hdl/div_writeback_stage.sv
hdl/div_unit_top.sv
tests/div_unit_tb.sv
